//--- filelist.f
game_pkg.sv
dino_motion.sv
obstacle_field.sv
game_ctrl.sv
dino_game_top.sv
tb_dino_game.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_dino_game \
    -f filelist.f --Mdir obj_dir -o sim_dino

./obj_dir/sim_dino > sim.log 2>&1 || true
cat sim.log

if grep -q "Some tests failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if ! grep -q "All tests passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation finished cleanly"

//--- tb_dino_game.sv
`timescale 1ns/1ps

module tb_dino_game;
    import game_pkg::*;

    localparam int jump_max    = 50;    // Upper bound on frames in the air
    localparam int rand_frames = 500;
    localparam int over_max    = 340;   // Longest wait for the next obstacle to arrive
    localparam int num_frames  = 2 + 4 + jump_max + 5 + 4 + rand_frames + over_max + 2;
    localparam int watchdog_ns = (num_frames + 20) * 8 * 4;

    logic        pclk;
    logic        rst;
    logic        start_pulse;
    logic        pause_pulse;
    logic        vsync;
    logic        jump;
    logic        duck;
    game_state_e game_state;
    dino_t       dino;
    obs_set_t    obstacles;
    logic        collision;

    // Reference model state
    game_state_e m_state;
    dino_t       m_dino;
    obs_set_t    m_obs;
    logic [9:0]  m_lfsr;
    int          m_last;
    logic [9:0]  m_off;

    dino_game_top dut_i (.*);

    always #2 pclk = ~pclk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string name);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0d ns: %s is %0h, expected %0h",
                                $time, name, got, exp));
        end
    endtask

    // One running frame of the game rules
    function automatic void ref_step(inout dino_t d, inout obs_set_t o, inout logic [9:0] lfsr,
                                     inout int last, inout logic [9:0] off,
                                     input logic jmp, input logic dk);
        obs_set_t old;
        int       nxt;
        old = o;
        if (d.y >= 10'd310) begin
            d.vel      = 10'sd0;
            d.ducking  = 1'b0;
            d.airborne = 1'b0;
            if (jmp) begin
                d.vel      = -10'sd18;
                d.y        = 10'(int'(d.y) - 18);
                d.airborne = 1'b1;
            end else if (dk) begin
                d.y       = 10'd312;
                d.ducking = 1'b1;
            end else begin
                d.y = 10'd310;
            end
        end else begin
            d.y        = 10'(int'(d.y) + int'(d.vel));   // Old velocity first
            d.vel      = 10'(int'(d.vel) + (dk ? 3 : 1));
            d.airborne = 1'b1;
            d.ducking  = 1'b0;
        end
        for (int i = 0; i < num_obs; i++) begin
            if (old[i].active) begin
                o[i].x = 13'(int'(old[i].x) - 4);
                if (int'(old[i].x) < -40) o[i].active = 1'b0;
            end
        end
        nxt = (last + 1) % 3;
        if (int'(old[last].x) < 640 - 300 - int'(off[8:0]) && !old[nxt].active) begin
            o[nxt].active = 1'b1;
            o[nxt].kind   = obs_kind_e'(lfsr[9:8]);
            o[nxt].x      = 13'sd640;
            last          = nxt;
            off           = lfsr;
        end
        lfsr = {lfsr[8:0], lfsr[9] ^ lfsr[6]};
    endfunction

    function automatic logic ref_collision(input dino_t d, input obs_set_t o);
        int   w;
        int   top;
        int   bot;
        int   ow;
        logic vert;
        logic hit;
        hit = 1'b0;
        w   = d.ducking ? 48 : 34;
        top = int'(d.y) + (d.ducking ? 12 : 0);
        bot = int'(d.y) + (d.ducking ? 38 : 40);
        for (int i = 0; i < num_obs; i++) begin
            case (o[i].kind)
                kind_small_cactus: begin
                    ow   = 14;
                    vert = bot > 320;
                end
                kind_big_cactus: begin
                    ow   = 20;
                    vert = bot > 310;
                end
                default: begin
                    ow   = 36;
                    vert = (bot > 286) && (top < 320);
                end
            endcase
            if (o[i].active && (160 + w > int'(o[i].x)) && (160 < int'(o[i].x) + ow) && vert)
                hit = 1'b1;
        end
        return hit;
    endfunction

    // Random play that still dodges most obstacles and returns {jump, duck}
    function automatic logic [1:0] steer(input obs_set_t o, input logic [31:0] r);
        logic [1:0] ctl;
        ctl = {r[3:0] == 4'd0, r[6:4] == 3'd0};
        for (int i = 0; i < num_obs; i++) begin
            if (o[i].active && int'(o[i].x) > 100 && int'(o[i].x) < 420) ctl = 2'b00;
        end
        for (int i = 0; i < num_obs; i++) begin
            if (o[i].active && o[i].kind >= kind_ptero_a) begin
                if (int'(o[i].x) >= 120 && int'(o[i].x) < 264) ctl = 2'b01;   // Duck under
            end else if (o[i].active && int'(o[i].x) >= 208 && int'(o[i].x) < 248) begin
                ctl = 2'b10;   // Jump over
            end
        end
        return ctl;
    endfunction

    task automatic model_restart();
        m_dino   = '{y: 10'd310, vel: 10'sd0, ducking: 1'b0, airborne: 1'b0};
        m_obs[0] = '{active: 1'b1, kind: kind_small_cactus, x: 13'sd630};
        m_obs[1] = '{active: 1'b0, kind: kind_small_cactus, x: 13'sd0};
        m_obs[2] = m_obs[1];
        m_last   = 0;
        m_off    = 10'd0;
    endtask

    // vsync high for 3 cycles, low for 5
    task automatic run_frame(input logic jmp, input logic dk);
        @(negedge pclk);
        vsync = 1'b1;
        jump  = jmp;
        duck  = dk;
        if (m_state == st_run) begin
            ref_step(m_dino, m_obs, m_lfsr, m_last, m_off, jmp, dk);
            if (ref_collision(m_dino, m_obs)) m_state = st_over;
        end
        repeat (3) @(negedge pclk);
        vsync = 1'b0;
        repeat (4) @(negedge pclk);
    endtask

    task automatic press(input logic start_btn);
        @(negedge pclk);
        start_pulse = start_btn;
        pause_pulse = !start_btn;
        @(negedge pclk);
        start_pulse = 1'b0;
        pause_pulse = 1'b0;
        if (start_btn) begin
            if (m_state == st_idle) begin
                m_state = st_run;
            end else if (m_state == st_over) begin
                m_state = st_idle;
                model_restart();   // LFSR keeps running
            end
        end else if (m_state == st_run) begin
            m_state = st_pause;
        end else if (m_state == st_pause) begin
            m_state = st_run;
        end
    endtask

    initial begin : compare_proc
        int low_cnt;
        low_cnt = 0;
        forever begin
            @(posedge pclk);
            low_cnt = (rst || vsync) ? 0 : low_cnt + 1;
            if (low_cnt == 3) begin
                @(negedge pclk);   // Middle of the low part of vsync
                check_eq(64'(game_state), 64'(m_state), "game_state");
                check_eq(64'(dino), 64'(m_dino), "dino");
                for (int i = 0; i < num_obs; i++) begin
                    check_eq(64'(obstacles[i]), 64'(m_obs[i]), $sformatf("obstacles[%0d]", i));
                end
                check_eq(64'(collision), 64'(ref_collision(m_dino, m_obs)), "collision");
            end
        end
    end

    initial begin
        #(watchdog_ns);
        abort_run("Timeout: the run did not finish within the expected number of frames");
    end

    initial begin
        logic [1:0] ctl;
        pclk        = 1'b0;
        rst         = 1'b1;
        start_pulse = 1'b0;
        pause_pulse = 1'b0;
        vsync       = 1'b0;
        jump        = 1'b0;
        duck        = 1'b0;
        m_state     = st_idle;
        m_lfsr      = 10'h001;
        model_restart();
        void'($urandom(32'h046658ff));
        repeat (4) @(negedge pclk);
        rst = 1'b0;

        repeat (2) run_frame(1'b0, 1'b0);   // Idle so nothing moves

        // Jump, then fast fall on the way down
        press(1'b1);
        repeat (4) run_frame(1'b1, 1'b0);
        for (int f = 0; f < jump_max && m_dino.airborne; f++) run_frame(1'b0, f > 12);

        repeat (3) run_frame(1'b0, 1'b1);   // Duck on the ground
        repeat (2) run_frame(1'b0, 1'b0);

        press(1'b0);
        repeat (3) run_frame(1'b1, 1'b1);   // Frozen while paused
        press(1'b0);
        run_frame(1'b0, 1'b0);

        for (int f = 0; f < rand_frames; f++) begin
            ctl = steer(m_obs, $urandom());
            run_frame(ctl[1], ctl[0]);
            if (m_state == st_over) begin
                press(1'b1);
                press(1'b1);
            end
        end

        // Stand still until the next obstacle hits
        for (int f = 0; f < over_max && m_state != st_over; f++) run_frame(1'b0, 1'b0);
        if (m_state != st_over) abort_run("The reference model never reached a collision");
        press(1'b1);
        run_frame(1'b0, 1'b0);
        press(1'b1);
        run_frame(1'b0, 1'b0);

        $display("All tests passed");
        $finish;
    end

endmodule

//--- dino_game_top.sv
`timescale 1ns/1ps

module dino_game_top (
    input  logic                  pclk,
    input  logic                  rst,
    input  logic                  start_pulse,
    input  logic                  pause_pulse,
    input  logic                  vsync,
    input  logic                  jump,       // Level
    input  logic                  duck,       // Level
    output game_pkg::game_state_e game_state,
    output game_pkg::dino_t       dino,
    output game_pkg::obs_set_t    obstacles,
    output logic                  collision
);

    logic run_tick;   // One step per running frame
    logic restart;

    game_ctrl ctrl_i (
        .pclk        (pclk),
        .rst         (rst),
        .vsync       (vsync),
        .start_pulse (start_pulse),
        .pause_pulse (pause_pulse),
        .dino        (dino),
        .obstacles   (obstacles),
        .game_state  (game_state),
        .run_tick    (run_tick),
        .restart     (restart),
        .collision   (collision)
    );

    dino_motion dino_i (
        .pclk     (pclk),
        .rst      (rst),
        .run_tick (run_tick),
        .restart  (restart),
        .jump     (jump),
        .duck     (duck),
        .dino     (dino)
    );

    obstacle_field obs_i (
        .pclk      (pclk),
        .rst       (rst),
        .run_tick  (run_tick),
        .restart   (restart),
        .obstacles (obstacles)
    );

endmodule

//--- game_ctrl.sv
`timescale 1ns/1ps

module game_ctrl (
    input  logic                  pclk,
    input  logic                  rst,
    input  logic                  vsync,
    input  logic                  start_pulse,
    input  logic                  pause_pulse,
    input  game_pkg::dino_t       dino,
    input  game_pkg::obs_set_t    obstacles,
    output game_pkg::game_state_e game_state,
    output logic                  run_tick,
    output logic                  restart,
    output logic                  collision
);
    import game_pkg::*;

    logic               vsync_q;
    logic               frame_edge;
    game_state_e        state_d;
    int                 box_w;
    int                 box_top;
    int                 box_bot;
    logic [num_obs-1:0] hit;

    // Box test against one slot
    function automatic logic slot_hit(input obstacle_t obs, input int w, input int top,
                                      input int bot);
        int   left;
        int   obs_w;
        logic vert;
        left = int'(obs.x);
        case (obs.kind)
            kind_small_cactus: begin
                obs_w = cactus_s_w;
                vert  = bot > int'(ground_y) - cactus_s_h;
            end
            kind_big_cactus: begin
                obs_w = cactus_b_w;
                vert  = bot > int'(ground_y) - cactus_b_h;
            end
            default: begin   // Both ptero kinds
                obs_w = ptero_w;
                vert  = (bot > int'(ground_y) - ptero_h - ptero_fly_offset) &&
                        (top < int'(ground_y) - ptero_fly_offset);
            end
        endcase
        return obs.active && (dino_x + w > left) && (dino_x < left + obs_w) && vert;
    endfunction

    assign frame_edge = vsync && !vsync_q;
    assign run_tick   = frame_edge && (game_state == st_run);

    always_comb begin
        if (dino.ducking) begin
            box_w   = dino_duck_w;
            box_top = int'(dino.y) + duck_box_trim;
            box_bot = int'(dino.y) + dino_duck_h;
        end else begin
            box_w   = dino_w;
            box_top = int'(dino.y);
            box_bot = int'(dino.y) + dino_h;
        end
        for (int i = 0; i < num_obs; i++) begin
            hit[i] = slot_hit(obstacles[i], box_w, box_top, box_bot);
        end
    end

    assign collision = |hit;

    always_comb begin
        state_d = game_state;
        case (game_state)
            st_idle:  if (start_pulse) state_d = st_run;
            st_run: begin
                if (collision)        state_d = st_over;   // Wins over pause
                else if (pause_pulse) state_d = st_pause;
            end
            st_pause: if (pause_pulse) state_d = st_run;
            st_over:  if (start_pulse) state_d = st_idle;
            default:  state_d = st_idle;
        endcase
    end

    always_ff @(posedge pclk or posedge rst) begin
        if (rst) begin
            game_state <= st_idle;
            vsync_q    <= 1'b0;
            restart    <= 1'b0;
        end else begin
            game_state <= state_d;
            vsync_q    <= vsync;
            restart    <= (game_state == st_over) && (state_d == st_idle);
        end
    end

    a_tick_in_run: assert property (
        @(posedge pclk) disable iff (rst)
        run_tick |-> (game_state == st_run)
    ) else $error("game_ctrl: frame step outside run state");

    a_restart_after_over: assert property (
        @(posedge pclk) disable iff (rst)
        restart |-> ($past(game_state) == st_over)
    ) else $error("game_ctrl: restart without game over");

endmodule

//--- obstacle_field.sv
`timescale 1ns/1ps

module obstacle_field (
    input  logic               pclk,
    input  logic               rst,
    input  logic               run_tick,
    input  logic               restart,
    output game_pkg::obs_set_t obstacles
);
    import game_pkg::*;

    logic [9:0]         lfsr;
    logic [9:0]         lfsr_d;
    logic [1:0]         last_idx;    // Slot spawned most recently
    logic [1:0]         next_idx;
    logic [9:0]         spawn_off;   // Extra random gap before next spawn
    logic signed [12:0] spawn_limit;
    logic               spawn_ok;
    obs_set_t           obs_d;

    // x^10 + x^7 + 1
    assign lfsr_d = {lfsr[8:0], lfsr[9] ^ lfsr[6]};

    // Round robin over the slots
    assign next_idx = (last_idx == 2'(num_obs - 1)) ? 2'd0 : last_idx + 2'd1;

    assign spawn_limit = spawn_x - min_gap - $signed({4'b0000, spawn_off[8:0]});

    // Decision taken on old slot values only
    assign spawn_ok = (obstacles[last_idx].x < spawn_limit) && !obstacles[next_idx].active;

    always_comb begin
        obs_d = obstacles;

        // Scroll and retire
        for (int i = 0; i < num_obs; i++) begin
            if (obstacles[i].active) begin
                obs_d[i].x = obstacles[i].x - scroll_step;
                if (obstacles[i].x < retire_x) begin
                    obs_d[i].active = 1'b0;   // Inactive slot keeps its x
                end
            end
        end

        if (spawn_ok) begin
            obs_d[next_idx].active = 1'b1;
            obs_d[next_idx].kind   = obs_kind_e'(lfsr[9:8]);
            obs_d[next_idx].x      = spawn_x;
        end
    end

    always_ff @(posedge pclk or posedge rst) begin
        if (rst) begin
            lfsr      <= lfsr_seed;
            obstacles <= obs_init;
            last_idx  <= 2'd0;
            spawn_off <= 10'd0;
        end else begin
            if (run_tick) begin
                lfsr <= lfsr_d;   // Keeps running across restarts
            end

            if (restart) begin
                obstacles <= obs_init;
                last_idx  <= 2'd0;
                spawn_off <= 10'd0;
            end else if (run_tick) begin
                obstacles <= obs_d;
                if (spawn_ok) begin
                    last_idx  <= next_idx;
                    spawn_off <= lfsr;
                end
            end
        end
    end

    // Slots only enter from the right edge and move left
    for (genvar g = 0; g < num_obs; g++) begin : g_slot_chk
        a_x_on_field: assert property (
            @(posedge pclk) disable iff (rst)
            obstacles[g].active |-> (obstacles[g].x <= spawn_x)
        ) else $error("obstacle_field: slot %0d beyond spawn edge", g);
    end

endmodule

//--- dino_motion.sv
`timescale 1ns/1ps

module dino_motion (
    input  logic            pclk,
    input  logic            rst,
    input  logic            run_tick,
    input  logic            restart,
    input  logic            jump,
    input  logic            duck,
    output game_pkg::dino_t dino
);
    import game_pkg::*;

    dino_t dino_d;
    logic  on_ground;

    // Anything at or below standing height counts as grounded
    assign on_ground = (dino.y >= dino_stand_y);

    always_comb begin
        dino_d = dino;
        if (on_ground) begin
            dino_d.vel      = 10'sd0;
            dino_d.ducking  = 1'b0;
            dino_d.airborne = 1'b0;
            if (jump) begin
                // Take off, first step already applied
                dino_d.vel      = -jump_vel;
                dino_d.y        = dino.y - $unsigned(jump_vel);
                dino_d.airborne = 1'b1;
            end else if (duck) begin
                dino_d.y       = dino_duck_y;
                dino_d.ducking = 1'b1;
            end else begin
                dino_d.y = dino_stand_y;   // Also snaps a landing overshoot
            end
        end else begin
            dino_d.vel      = dino.vel + (duck ? fast_fall : gravity);
            dino_d.y        = dino.y + $unsigned(dino.vel);   // Old velocity
            dino_d.airborne = 1'b1;
            dino_d.ducking  = 1'b0;   // No ducking in the air
        end
    end

    always_ff @(posedge pclk or posedge rst) begin
        if (rst) begin
            dino <= dino_init;
        end else if (restart) begin
            dino <= dino_init;
        end else if (run_tick) begin
            dino <= dino_d;
        end
    end

    a_duck_air_excl: assert property (
        @(posedge pclk) disable iff (rst)
        !(dino.ducking && dino.airborne)
    ) else $error("dino_motion: ducking and airborne both set");

endmodule

//--- game_pkg.sv
package game_pkg;

    // Playfield and dinosaur geometry, in pixels
    localparam logic [9:0] ground_y = 10'd350;
    localparam int dino_x        = 160;   // Fixed left edge
    localparam int dino_w        = 34;
    localparam int dino_h        = 40;
    localparam int dino_duck_w   = 48;
    localparam int dino_duck_h   = 38;
    localparam int duck_box_trim = 12;    // Box top moves down while ducking

    // Obstacle sizes
    localparam int cactus_s_w       = 14;
    localparam int cactus_s_h       = 30;
    localparam int cactus_b_w       = 20;
    localparam int cactus_b_h       = 40;
    localparam int ptero_w          = 36;
    localparam int ptero_h          = 34;
    localparam int ptero_fly_offset = 30; // Height of ptero bottom above ground

    // Rest heights of the dinosaur top edge
    localparam logic [9:0] dino_stand_y = ground_y - 10'(dino_h);
    localparam logic [9:0] dino_duck_y  = ground_y - 10'(dino_duck_h);

    // Vertical motion per frame
    localparam logic signed [9:0] jump_vel  = 10'sd18;
    localparam logic signed [9:0] gravity   = 10'sd1;
    localparam logic signed [9:0] fast_fall = 10'sd3;   // Duck held in the air

    // Obstacle field
    localparam logic signed [12:0] scroll_step = 13'sd4;
    localparam logic signed [12:0] spawn_x     = 13'sd640;
    localparam logic signed [12:0] first_obs_x = 13'sd630;
    localparam logic signed [12:0] retire_x    = -13'sd40;
    localparam logic signed [12:0] min_gap     = 13'sd300;
    localparam logic [9:0]         lfsr_seed   = 10'h001;
    localparam int                 num_obs     = 3;

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_pause,
        st_over
    } game_state_e;

    typedef enum logic [1:0] {
        kind_small_cactus,
        kind_big_cactus,
        kind_ptero_a,
        kind_ptero_b
    } obs_kind_e;

    typedef struct packed {
        logic [9:0]        y;         // Top edge
        logic signed [9:0] vel;       // Positive is downwards
        logic              ducking;
        logic              airborne;
    } dino_t;

    typedef struct packed {
        logic               active;
        obs_kind_e          kind;
        logic signed [12:0] x;        // Left edge, may sit off screen
    } obstacle_t;

    typedef obstacle_t [num_obs-1:0] obs_set_t;

    // Start values, also used on restart
    localparam dino_t dino_init = '{y: dino_stand_y, vel: 10'sd0, ducking: 1'b0, airborne: 1'b0};
    localparam obstacle_t obs_first = '{active: 1'b1, kind: kind_small_cactus, x: first_obs_x};
    localparam obstacle_t obs_idle = '{active: 1'b0, kind: kind_small_cactus, x: 13'sd0};
    localparam obs_set_t obs_init = {obs_idle, obs_idle, obs_first}; // Slot 0 rightmost

endpackage
